//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - rtl/pipe_ctrl_pkg.sv
  - rtl/stage_track.sv
  - rtl/operand_bypass.sv
  - rtl/trap_csr.sv
  - rtl/redirect_unit.sv
  - rtl/pipe_ctrl.sv
  - target: test
    files:
      - test/tb_pipe_ctrl.sv

//--- rtl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import pipe_ctrl_pkg::*; (
    input  logic              id_valid,
    input  logic [reg_aw-1:0] id_rs1,
    input  logic [reg_aw-1:0] id_rs2,
    input  logic [xlen-1:0]   id_rs1_value,
    input  logic [xlen-1:0]   id_rs2_value,

    input  logic              ex_valid,
    input  logic [reg_aw-1:0] ex_rd,
    input  logic              ex_reg_wen,
    input  logic              ex_mem_ren,

    input  logic              mem_valid,
    input  logic [reg_aw-1:0] mem_rd,
    input  logic              mem_reg_wen,
    input  logic              mem_mem_ren,

    input  logic [xlen-1:0]   ex_result,
    input  logic [xlen-1:0]   mem_alu_result,
    input  logic [xlen-1:0]   mem_rdata,

    output logic              id_ready,
    output logic [xlen-1:0]   ex_rs1_in,
    output logic [xlen-1:0]   ex_rs2_in
);

    logic       ex_wr;
    logic       mem_wr;
    logic       rs1_ex_hit;
    logic       rs2_ex_hit;
    logic       load_use;
    logic [1:0] rs1_sel;
    logic [1:0] rs2_sel;

    // newest producer wins, load data not yet available in execute
    function automatic logic [1:0] pick_src(input logic [reg_aw-1:0] rs);
        if (ex_wr && ex_rd == rs && !ex_mem_ren)
            return fwd_ex;
        else if (mem_wr && mem_rd == rs)
            return mem_mem_ren ? fwd_mem_load : fwd_mem_alu;
        else
            return fwd_none;
    endfunction

    function automatic logic [xlen-1:0] mux_src(input logic [1:0] sel,
                                                input logic [xlen-1:0] rf_value);
        case (sel)
            fwd_ex:       return ex_result;
            fwd_mem_alu:  return mem_alu_result;
            fwd_mem_load: return mem_rdata;
            default:      return rf_value;
        endcase
    endfunction

    // x0 never forwards
    assign ex_wr  = ex_valid && ex_reg_wen && (ex_rd != '0);
    assign mem_wr = mem_valid && mem_reg_wen && (mem_rd != '0);

    assign rs1_ex_hit = ex_wr && (ex_rd == id_rs1);
    assign rs2_ex_hit = ex_wr && (ex_rd == id_rs2);
    assign load_use   = id_valid && ex_mem_ren && (rs1_ex_hit || rs2_ex_hit);
    assign id_ready   = !load_use;

    assign rs1_sel   = pick_src(id_rs1);
    assign rs2_sel   = pick_src(id_rs2);
    assign ex_rs1_in = mux_src(rs1_sel, id_rs1_value);
    assign ex_rs2_in = mux_src(rs2_sel, id_rs2_value);

endmodule

//--- rtl/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl import pipe_ctrl_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,

    input  logic              id_valid,
    input  logic [xlen-1:0]   id_pc,
    input  logic [xlen-1:0]   id_imm,
    input  logic [reg_aw-1:0] id_rs1,
    input  logic [reg_aw-1:0] id_rs2,
    input  logic [xlen-1:0]   id_rs1_value,
    input  logic [xlen-1:0]   id_rs2_value,
    input  logic [reg_aw-1:0] id_rd,
    input  logic              id_reg_wen,
    input  logic              id_mem_ren,
    input  logic              id_jump,
    input  logic              id_branch,
    input  logic              id_fence_i,
    input  logic              id_mret,
    input  logic              id_ecall,

    input  logic [xlen-1:0]   ex_result,
    input  logic [xlen-1:0]   mem_rdata,

    input  logic              csr_wen,
    input  logic [xlen-1:0]   csr_wdata,

    output logic [xlen-1:0]   ex_rs1_in,
    output logic [xlen-1:0]   ex_rs2_in,
    output logic              id_ready,
    output logic [xlen-1:0]   dnpc,
    output logic              dnpc_flag,
    output logic              id_inst_clear,
    output logic              icache_clr,
    output logic              ex_valid,
    output logic              mem_valid
);

    logic [xlen-1:0]   ex_pc;
    logic [xlen-1:0]   ex_imm;
    logic [reg_aw-1:0] ex_rd;
    logic              ex_reg_wen;
    logic              ex_mem_ren;
    logic              ex_jump;
    logic              ex_branch;
    logic              ex_fence_i;
    logic [reg_aw-1:0] mem_rd;
    logic              mem_reg_wen;
    logic              mem_mem_ren;
    logic [xlen-1:0]   mem_alu_result;
    logic [xlen-1:0]   mtvec;
    logic [xlen-1:0]   mepc;
    logic              trap_take;

    stage_track stage_track_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .id_valid       (id_valid),
        .id_ready       (id_ready),
        .id_inst_clear  (id_inst_clear),
        .id_pc          (id_pc),
        .id_imm         (id_imm),
        .id_rd          (id_rd),
        .id_reg_wen     (id_reg_wen),
        .id_mem_ren     (id_mem_ren),
        .id_jump        (id_jump),
        .id_branch      (id_branch),
        .id_fence_i     (id_fence_i),
        .ex_result      (ex_result),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_imm         (ex_imm),
        .ex_rd          (ex_rd),
        .ex_reg_wen     (ex_reg_wen),
        .ex_mem_ren     (ex_mem_ren),
        .ex_jump        (ex_jump),
        .ex_branch      (ex_branch),
        .ex_fence_i     (ex_fence_i),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_reg_wen    (mem_reg_wen),
        .mem_mem_ren    (mem_mem_ren),
        .mem_alu_result (mem_alu_result)
    );

    operand_bypass operand_bypass_i (
        .id_valid       (id_valid),
        .id_rs1         (id_rs1),
        .id_rs2         (id_rs2),
        .id_rs1_value   (id_rs1_value),
        .id_rs2_value   (id_rs2_value),
        .ex_valid       (ex_valid),
        .ex_rd          (ex_rd),
        .ex_reg_wen     (ex_reg_wen),
        .ex_mem_ren     (ex_mem_ren),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_reg_wen    (mem_reg_wen),
        .mem_mem_ren    (mem_mem_ren),
        .ex_result      (ex_result),
        .mem_alu_result (mem_alu_result),
        .mem_rdata      (mem_rdata),
        .id_ready       (id_ready),
        .ex_rs1_in      (ex_rs1_in),
        .ex_rs2_in      (ex_rs2_in)
    );

    trap_csr trap_csr_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .csr_wen   (csr_wen),
        .csr_wdata (csr_wdata),
        .trap_take (trap_take),
        .id_ecall  (id_ecall),
        .id_pc     (id_pc),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    redirect_unit redirect_unit_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_jump       (ex_jump),
        .ex_branch     (ex_branch),
        .ex_fence_i    (ex_fence_i),
        .ex_pc         (ex_pc),
        .ex_imm        (ex_imm),
        .ex_result     (ex_result),
        .id_valid      (id_valid),
        .id_mret       (id_mret),
        .id_ecall      (id_ecall),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .dnpc          (dnpc),
        .dnpc_flag     (dnpc_flag),
        .id_inst_clear (id_inst_clear),
        .trap_take     (trap_take),
        .icache_clr    (icache_clr)
    );

endmodule

//--- rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // datapath widths
    localparam int xlen   = 32;
    localparam int reg_aw = 5;

    // operand source select, one per decode operand
    localparam logic [1:0] fwd_none     = 2'b00;  // register file value
    localparam logic [1:0] fwd_ex       = 2'b01;  // alu result now in execute
    localparam logic [1:0] fwd_mem_alu  = 2'b10;  // alu result held in memory stage
    localparam logic [1:0] fwd_mem_load = 2'b11;  // load data from memory stage

    // trap vector after reset
    localparam logic [xlen-1:0] mtvec_reset = 32'h3000_0000;

    // fixed rv32 instruction size, no compressed support
    localparam logic [xlen-1:0] pc_step = 32'd4;

endpackage

//--- rtl/redirect_unit.sv
`timescale 1ns/1ps

module redirect_unit import pipe_ctrl_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,

    input  logic            ex_valid,
    input  logic            ex_jump,
    input  logic            ex_branch,
    input  logic            ex_fence_i,
    input  logic [xlen-1:0] ex_pc,
    input  logic [xlen-1:0] ex_imm,
    input  logic [xlen-1:0] ex_result,

    input  logic            id_valid,
    input  logic            id_mret,
    input  logic            id_ecall,

    input  logic [xlen-1:0] mtvec,
    input  logic [xlen-1:0] mepc,

    output logic [xlen-1:0] dnpc,
    output logic            dnpc_flag,
    output logic            id_inst_clear,
    output logic            trap_take,
    output logic            icache_clr
);

    logic            br_taken;
    logic            ex_redirect;
    logic [xlen-1:0] ex_target;
    logic [xlen-1:0] trap_target;

    assign br_taken    = ex_branch && ex_result[0];  // bit 0 carries the compare
    assign ex_redirect = ex_valid && (ex_jump || ex_fence_i || br_taken);

    // older instruction in execute wins over a decode trap
    assign trap_take = id_valid && (id_ecall || id_mret) && !ex_redirect;

    assign ex_target   = ex_jump  ? ex_result :
                         br_taken ? ex_pc + ex_imm :
                                    ex_pc + pc_step;
    assign trap_target = id_mret ? mepc : mtvec;

    assign dnpc          = ex_redirect ? ex_target : trap_target;
    assign dnpc_flag     = ex_redirect || trap_take;
    assign id_inst_clear = ex_redirect || trap_take;  // wrong-path decode slot

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            icache_clr <= 1'b0;
        end else begin
            icache_clr <= ex_valid && ex_fence_i;
        end
    end

    // target mux assumes one control flow kind per instruction
    a_one_ex_kind: assert property (
        @(posedge clock) disable iff (!rst_n)
        ex_valid |-> $onehot0({ex_jump, ex_branch, ex_fence_i})
    );

endmodule

//--- rtl/stage_track.sv
`timescale 1ns/1ps

module stage_track import pipe_ctrl_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,

    input  logic              id_valid,
    input  logic              id_ready,
    input  logic              id_inst_clear,
    input  logic [xlen-1:0]   id_pc,
    input  logic [xlen-1:0]   id_imm,
    input  logic [reg_aw-1:0] id_rd,
    input  logic              id_reg_wen,
    input  logic              id_mem_ren,
    input  logic              id_jump,
    input  logic              id_branch,
    input  logic              id_fence_i,
    input  logic [xlen-1:0]   ex_result,

    output logic              ex_valid,
    output logic [xlen-1:0]   ex_pc,
    output logic [xlen-1:0]   ex_imm,
    output logic [reg_aw-1:0] ex_rd,
    output logic              ex_reg_wen,
    output logic              ex_mem_ren,
    output logic              ex_jump,
    output logic              ex_branch,
    output logic              ex_fence_i,

    output logic              mem_valid,
    output logic [reg_aw-1:0] mem_rd,
    output logic              mem_reg_wen,
    output logic              mem_mem_ren,
    output logic [xlen-1:0]   mem_alu_result
);

    logic ex_load;

    // stall or flush turns the execute entry into a bubble
    assign ex_load = id_valid && id_ready && !id_inst_clear;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            ex_reg_wen  <= 1'b0;
            ex_mem_ren  <= 1'b0;
            ex_jump     <= 1'b0;
            ex_branch   <= 1'b0;
            ex_fence_i  <= 1'b0;
            mem_valid   <= 1'b0;
            mem_reg_wen <= 1'b0;
            mem_mem_ren <= 1'b0;
        end else begin
            ex_valid    <= ex_load;
            ex_reg_wen  <= ex_load && id_reg_wen;  // bubbles carry no side effects
            ex_mem_ren  <= ex_load && id_mem_ren;
            ex_jump     <= ex_load && id_jump;
            ex_branch   <= ex_load && id_branch;
            ex_fence_i  <= ex_load && id_fence_i;
            mem_valid   <= ex_valid;
            mem_reg_wen <= ex_reg_wen;
            mem_mem_ren <= ex_mem_ren;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_load) begin
            ex_pc  <= id_pc;
            ex_imm <= id_imm;
            ex_rd  <= id_rd;
        end
        mem_rd         <= ex_rd;
        mem_alu_result <= ex_result;
    end

    // stalled decode instruction must still be there to enter later
    a_stall_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        id_valid && !id_ready && !id_inst_clear |=>
            id_valid && $stable(id_pc) && $stable(id_rd)
    );

endmodule

//--- rtl/trap_csr.sv
`timescale 1ns/1ps

module trap_csr import pipe_ctrl_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,

    input  logic            csr_wen,
    input  logic [xlen-1:0] csr_wdata,

    input  logic            trap_take,
    input  logic            id_ecall,
    input  logic [xlen-1:0] id_pc,

    output logic [xlen-1:0] mtvec,
    output logic [xlen-1:0] mepc
);

    logic ecall_take;

    // mret also traps but leaves mepc alone
    assign ecall_take = trap_take && id_ecall;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= mtvec_reset;
        end else if (csr_wen) begin
            mtvec <= csr_wdata;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (ecall_take) begin
            mepc <= id_pc;  // return address is the ecall itself
        end
    end

endmodule

//--- src.f
rtl/pipe_ctrl_pkg.sv
rtl/stage_track.sv
rtl/operand_bypass.sv
rtl/trap_csr.sv
rtl/redirect_unit.sv
rtl/pipe_ctrl.sv
test/tb_pipe_ctrl.sv

//--- test/tb_pipe_ctrl.sv
`timescale 1ns/1ps

module tb_pipe_ctrl import pipe_ctrl_pkg::*; ();

    localparam int reset_cycles = 5;
    localparam int test_cycles  = 300;
    localparam int random_tests = 4;
    localparam int cycle_limit  = reset_cycles + 1 + random_tests * test_cycles + 100;

    logic              clock;
    logic              rst_n;
    logic              id_valid;
    logic [xlen-1:0]   id_pc;
    logic [xlen-1:0]   id_imm;
    logic [reg_aw-1:0] id_rs1;
    logic [reg_aw-1:0] id_rs2;
    logic [xlen-1:0]   id_rs1_value;
    logic [xlen-1:0]   id_rs2_value;
    logic [reg_aw-1:0] id_rd;
    logic              id_reg_wen;
    logic              id_mem_ren;
    logic              id_jump;
    logic              id_branch;
    logic              id_fence_i;
    logic              id_mret;
    logic              id_ecall;
    logic [xlen-1:0]   ex_result;
    logic [xlen-1:0]   mem_rdata;
    logic              csr_wen;
    logic [xlen-1:0]   csr_wdata;
    logic [xlen-1:0]   ex_rs1_in;
    logic [xlen-1:0]   ex_rs2_in;
    logic              id_ready;
    logic [xlen-1:0]   dnpc;
    logic              dnpc_flag;
    logic              id_inst_clear;
    logic              icache_clr;
    logic              ex_valid;
    logic              mem_valid;

    // reference model state
    logic              m_ex_valid, m_ex_reg_wen, m_ex_mem_ren;
    logic              m_ex_jump, m_ex_branch, m_ex_fence_i;
    logic [xlen-1:0]   m_ex_pc, m_ex_imm;
    logic [reg_aw-1:0] m_ex_rd, m_mem_rd;
    logic              m_mem_valid, m_mem_reg_wen, m_mem_mem_ren;
    logic [xlen-1:0]   m_mem_alu, m_mtvec, m_mepc;
    logic              m_icache_clr;

    // expected combinational outputs for the current cycle
    logic              exp_ready, exp_flag, exp_take_ecall;
    logic [xlen-1:0]   exp_dnpc, exp_rs1, exp_rs2;

    // stall and flush state carried across tests
    logic              hold = 1'b0;
    logic              flushed = 1'b0;

    integer seed = 18791;
    int     test_errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycle_count = 0;

    pipe_ctrl pipe_ctrl_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("CHECK FAILED %s %s: expected %h actual %h", test, what, expected, actual);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        $display("test %-10s %s, %0d errors", name, test_errors == 0 ? "ok" : "failed",
                 test_errors);
        if (test_errors == 0) pass_count++;
        else fail_count++;
        test_errors = 0;
    endtask

    task automatic idle_inputs();
        id_valid = 1'b0;
        id_pc = '0;
        id_imm = '0;
        id_rs1 = '0;
        id_rs2 = '0;
        id_rs1_value = '0;
        id_rs2_value = '0;
        id_rd = '0;
        id_reg_wen = 1'b0;
        id_mem_ren = 1'b0;
        id_jump = 1'b0;
        id_branch = 1'b0;
        id_fence_i = 1'b0;
        id_mret = 1'b0;
        id_ecall = 1'b0;
        ex_result = '0;
        mem_rdata = '0;
        csr_wen = 1'b0;
        csr_wdata = '0;
    endtask

    task automatic reset_model();
        {m_ex_valid, m_ex_reg_wen, m_ex_mem_ren, m_ex_jump, m_ex_branch, m_ex_fence_i} = '0;
        {m_mem_valid, m_mem_reg_wen, m_mem_mem_ren, m_icache_clr} = '0;
        m_ex_pc = '0;
        m_ex_imm = '0;
        m_ex_rd = '0;
        m_mem_rd = '0;
        m_mem_alu = '0;
        m_mtvec = mtvec_reset;
        m_mepc = '0;
    endtask

    // kind 0 alu only, 1 loads, 2 control flow, 3 traps and csr writes
    task automatic new_instruction(input int kind);
        int pick;
        pick = {$random(seed)} % 100;
        id_valid     = ({$random(seed)} % 8) != 0;
        id_pc        = $random(seed) & 32'hffff_fffc;
        id_imm       = $random(seed) & 32'h0000_0ffc;
        id_rs1       = $random(seed) & 7;  // small index range, many hazards
        id_rs2       = $random(seed) & 7;
        id_rd        = $random(seed) & 7;
        id_rs1_value = $random(seed);
        id_rs2_value = $random(seed);
        id_reg_wen   = ({$random(seed)} % 4) != 0;
        id_mem_ren   = 1'b0;
        id_jump      = 1'b0;
        id_branch    = 1'b0;
        id_fence_i   = 1'b0;
        id_ecall     = 1'b0;
        id_mret      = 1'b0;
        case (kind)
            1: id_mem_ren = pick < 40;
            2: begin
                id_jump    = pick < 15;
                id_branch  = pick >= 15 && pick < 35;
                id_fence_i = pick >= 35 && pick < 45;
                id_mem_ren = pick >= 45 && pick < 65;
            end
            3: begin
                id_ecall   = pick < 12;
                id_mret    = pick >= 12 && pick < 20;
                id_branch  = pick >= 20 && pick < 30;
                id_mem_ren = pick >= 30 && pick < 50;
            end
            default: ;
        endcase
        if (id_branch || id_fence_i || id_ecall || id_mret)
            id_reg_wen = 1'b0;
        if (id_ecall || id_mret) begin  // no source operands
            id_rs1 = '0;
            id_rs2 = '0;
        end
    endtask

    task automatic drive_datapath(input int kind);
        ex_result = $random(seed);
        mem_rdata = $random(seed);
        csr_wen   = (kind == 3) && ({$random(seed)} % 10 == 0);
        csr_wdata = $random(seed) & 32'hffff_fffc;
    endtask

    function automatic logic [xlen-1:0] newest_value(input logic [reg_aw-1:0] rs,
                                                     input logic [xlen-1:0] rf_value);
        // a load in execute has no data yet
        if (rs != 0 && m_ex_valid && m_ex_reg_wen && m_ex_rd == rs && !m_ex_mem_ren)
            return ex_result;
        if (rs != 0 && m_mem_valid && m_mem_reg_wen && m_mem_rd == rs)
            return m_mem_mem_ren ? mem_rdata : m_mem_alu;
        return rf_value;
    endfunction

    task automatic predict_comb();
        logic taken;
        logic ex_redirect;
        logic trap;
        logic rs1_load_hit;
        logic rs2_load_hit;
        taken          = m_ex_branch && ex_result[0];
        ex_redirect    = m_ex_valid && (m_ex_jump || m_ex_fence_i || taken);
        trap           = id_valid && (id_ecall || id_mret) && !ex_redirect;
        exp_flag       = ex_redirect || trap;
        exp_take_ecall = trap && id_ecall;
        if (ex_redirect)
            exp_dnpc = m_ex_jump ? ex_result : taken ? m_ex_pc + m_ex_imm : m_ex_pc + 32'd4;
        else
            exp_dnpc = id_mret ? m_mepc : m_mtvec;
        rs1_load_hit = id_rs1 != 0 && id_rs1 == m_ex_rd;
        rs2_load_hit = id_rs2 != 0 && id_rs2 == m_ex_rd;
        exp_ready = !(id_valid && m_ex_valid && m_ex_mem_ren && m_ex_reg_wen
                      && (rs1_load_hit || rs2_load_hit));
        exp_rs1 = newest_value(id_rs1, id_rs1_value);
        exp_rs2 = newest_value(id_rs2, id_rs2_value);
    endtask

    task automatic advance_model();
        logic enter;
        enter = id_valid && exp_ready && !exp_flag;
        m_icache_clr  = m_ex_valid && m_ex_fence_i;
        m_mem_valid   = m_ex_valid;
        m_mem_rd      = m_ex_rd;
        m_mem_reg_wen = m_ex_reg_wen;
        m_mem_mem_ren = m_ex_mem_ren;
        m_mem_alu     = ex_result;
        m_ex_valid    = enter;
        m_ex_reg_wen  = enter && id_reg_wen;
        m_ex_mem_ren  = enter && id_mem_ren;
        m_ex_jump     = enter && id_jump;
        m_ex_branch   = enter && id_branch;
        m_ex_fence_i  = enter && id_fence_i;
        if (enter) begin
            m_ex_pc  = id_pc;
            m_ex_imm = id_imm;
            m_ex_rd  = id_rd;
        end
        if (csr_wen)
            m_mtvec = csr_wdata;
        if (exp_take_ecall)
            m_mepc = id_pc;
    endtask

    task automatic check_outputs(input string name);
        if (ex_valid !== m_ex_valid) report_mismatch(name, "ex_valid", m_ex_valid, ex_valid);
        if (mem_valid !== m_mem_valid) report_mismatch(name, "mem_valid", m_mem_valid, mem_valid);
        if (icache_clr !== m_icache_clr)
            report_mismatch(name, "icache_clr", m_icache_clr, icache_clr);
        if (id_ready !== exp_ready) report_mismatch(name, "id_ready", exp_ready, id_ready);
        if (dnpc_flag !== exp_flag) report_mismatch(name, "dnpc_flag", exp_flag, dnpc_flag);
        if (id_inst_clear !== exp_flag)
            report_mismatch(name, "id_inst_clear", exp_flag, id_inst_clear);
        if (exp_flag && dnpc !== exp_dnpc) report_mismatch(name, "dnpc", exp_dnpc, dnpc);
        if (ex_rs1_in !== exp_rs1) report_mismatch(name, "ex_rs1_in", exp_rs1, ex_rs1_in);
        if (ex_rs2_in !== exp_rs2) report_mismatch(name, "ex_rs2_in", exp_rs2, ex_rs2_in);
    endtask

    task automatic check_reset();
        #1;
        predict_comb();
        if (ex_valid !== 1'b0) report_mismatch("reset", "ex_valid", 0, ex_valid);
        if (mem_valid !== 1'b0) report_mismatch("reset", "mem_valid", 0, mem_valid);
        if (dnpc_flag !== 1'b0) report_mismatch("reset", "dnpc_flag", 0, dnpc_flag);
        if (id_inst_clear !== 1'b0) report_mismatch("reset", "id_inst_clear", 0, id_inst_clear);
        if (icache_clr !== 1'b0) report_mismatch("reset", "icache_clr", 0, icache_clr);
        if (id_ready !== 1'b1) report_mismatch("reset", "id_ready", 1, id_ready);
        @(posedge clock);
        advance_model();
        finish_test("reset");
    endtask

    task automatic run_random(input string name, input int kind);
        for (int c = 0; c < test_cycles; c++) begin
            @(negedge clock);
            if (!hold)
                new_instruction(kind);  // stalled decode keeps its instruction
            drive_datapath(kind);
            #1;
            predict_comb();
            check_outputs(name);
            if (flushed && ex_valid) begin
                $display("%s: a flushed decode instruction reached execute", name);
                test_errors++;
            end
            hold    = id_valid && !exp_ready && !exp_flag;
            flushed = id_valid && exp_flag;
            @(posedge clock);
            advance_model();
        end
        finish_test(name);
    endtask

    initial begin
        idle_inputs();
        reset_model();
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        rst_n = 1'b1;
        check_reset();
        run_random("forwarding", 0);
        run_random("load_use", 1);
        run_random("redirect", 2);
        run_random("traps", 3);
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
